/* source/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// data path word
`define DATA_WIDTH 16

// register file size
`define REG_COUNT 8
`define REG_INDEX_WIDTH 3

// instruction opcode field
`define OPCODE_WIDTH 5

`endif

/* source/decodePkg.sv */
`include "decode_config.svh"

package decodePkg;

    // register format: opcode rs rt rd func
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]    opcode;
        logic [`REG_INDEX_WIDTH-1:0] rs;
        logic [`REG_INDEX_WIDTH-1:0] rt;
        logic [`REG_INDEX_WIDTH-1:0] rd;
        logic [1:0]                  func;
    } regFormat_t;

    // immediate format, rd sits in bits 7 to 5
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]    opcode;
        logic [`REG_INDEX_WIDTH-1:0] rs;
        logic [`REG_INDEX_WIDTH-1:0] rd;
        logic [4:0]                  imm;
    } immFormat_t;

    // jump and load-byte format
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [10:0]              disp;
    } jumpFormat_t;

    typedef union packed {
        regFormat_t  regView;
        immFormat_t  immView;
        jumpFormat_t jumpView;
    } instrWord_t;

    typedef enum logic [1:0] {
        DEST_RD   = 2'd0,
        DEST_RT   = 2'd1,
        DEST_RS   = 2'd2,
        DEST_LINK = 2'd3
    } regDest_t;

    typedef enum logic [2:0] {
        SRC_ALU  = 3'd0,
        SRC_MEM  = 3'd1,
        SRC_IMM8 = 3'd2,
        SRC_LINK = 3'd3,
        SRC_BTR  = 3'd4
    } regSource_t;

    typedef struct packed {
        regDest_t   regDst;
        regSource_t regDataSrc;
        logic [2:0] aluSrc1;
        logic [2:0] aluSrc2;
        logic [2:0] aluOp;
        logic       regWriteEn;
        logic       memEn;
        logic       memWr;
        logic       branch;
        logic       jump;
        logic       exception;
        logic       cin;
        logic       invA;
        logic       invB;
        logic       sign;
        logic       signedExt;
        logic       dump;
    } controlSignals_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] immEight;
        logic [`DATA_WIDTH-1:0] immEleven;
        logic [`DATA_WIDTH-1:0] immFive;
        logic [`DATA_WIDTH-1:0] bitReverse;
    } formattedOperands_t;

    localparam logic [`OPCODE_WIDTH-1:0] OP_HALT  = 5'b00000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_NOP   = 5'b00001;
    localparam logic [`OPCODE_WIDTH-1:0] OP_J     = 5'b00100;
    localparam logic [`OPCODE_WIDTH-1:0] OP_JAL   = 5'b00110;
    localparam logic [`OPCODE_WIDTH-1:0] OP_ADDI  = 5'b01000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_SUBI  = 5'b01001;
    localparam logic [`OPCODE_WIDTH-1:0] OP_XORI  = 5'b01010;
    localparam logic [`OPCODE_WIDTH-1:0] OP_ANDNI = 5'b01011;
    localparam logic [`OPCODE_WIDTH-1:0] OP_BEQZ  = 5'b01100;
    localparam logic [`OPCODE_WIDTH-1:0] OP_ST    = 5'b10000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_LD    = 5'b10001;
    localparam logic [`OPCODE_WIDTH-1:0] OP_SLBI  = 5'b10010;
    localparam logic [`OPCODE_WIDTH-1:0] OP_STU   = 5'b10011;
    localparam logic [`OPCODE_WIDTH-1:0] OP_LBI   = 5'b11000;
    localparam logic [`OPCODE_WIDTH-1:0] OP_BTR   = 5'b11001;
    localparam logic [`OPCODE_WIDTH-1:0] OP_ALU   = 5'b11011;

    // function field of OP_ALU
    localparam logic [1:0] FN_ADD  = 2'b00;
    localparam logic [1:0] FN_SUB  = 2'b01;
    localparam logic [1:0] FN_XOR  = 2'b10;
    localparam logic [1:0] FN_ANDN = 2'b11;

    // alu operand selects
    localparam logic [2:0] ALU1_REG   = 3'd0;
    localparam logic [2:0] ALU1_PC    = 3'd1;
    localparam logic [2:0] ALU2_REG   = 3'd0;
    localparam logic [2:0] ALU2_IMM5  = 3'd1;
    localparam logic [2:0] ALU2_IMM8  = 3'd2;
    localparam logic [2:0] ALU2_IMM11 = 3'd3;

    // alu operations, subtract is add with invA and cin
    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_XOR  = 3'd1;
    localparam logic [2:0] ALU_AND  = 3'd2;
    localparam logic [2:0] ALU_SLBI = 3'd3;

endpackage

/* source/controlDecoder.sv */
module controlDecoder (
    input  decodePkg::instrWord_t      instr,
    output decodePkg::controlSignals_t ctrl
);
    import decodePkg::*;

    always_comb begin
        // quiet defaults, overridden per opcode
        ctrl            = '0;
        ctrl.regDst     = DEST_RD;
        ctrl.regDataSrc = SRC_ALU;
        ctrl.aluSrc1    = ALU1_REG;
        ctrl.aluSrc2    = ALU2_REG;
        ctrl.aluOp      = ALU_ADD;
        ctrl.signedExt  = 1'b1;

        case (instr.regView.opcode)
            OP_HALT: begin
                ctrl.dump = 1'b1;
            end
            OP_NOP: begin
            end
            OP_ADDI: begin
                ctrl.regDst     = DEST_RT;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.sign       = 1'b1;
            end
            OP_SUBI: begin
                // imm minus rs
                ctrl.regDst     = DEST_RT;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.invA       = 1'b1;
                ctrl.cin        = 1'b1;
                ctrl.sign       = 1'b1;
            end
            OP_XORI: begin
                ctrl.regDst     = DEST_RT;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.aluOp      = ALU_XOR;
                ctrl.signedExt  = 1'b0;
            end
            OP_ANDNI: begin
                ctrl.regDst     = DEST_RT;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.aluOp      = ALU_AND;
                ctrl.invB       = 1'b1;
                ctrl.signedExt  = 1'b0;
            end
            OP_ALU: begin
                ctrl.regWriteEn = 1'b1;
                case (instr.regView.func)
                    FN_ADD: begin
                        ctrl.sign = 1'b1;
                    end
                    FN_SUB: begin
                        ctrl.invA = 1'b1;
                        ctrl.cin  = 1'b1;
                        ctrl.sign = 1'b1;
                    end
                    FN_XOR: begin
                        ctrl.aluOp = ALU_XOR;
                    end
                    default: begin
                        ctrl.aluOp = ALU_AND;
                        ctrl.invB  = 1'b1;
                    end
                endcase
            end
            OP_LD: begin
                ctrl.regDst     = DEST_RT;
                ctrl.regDataSrc = SRC_MEM;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.memEn      = 1'b1;
            end
            OP_ST: begin
                ctrl.aluSrc2 = ALU2_IMM5;
                ctrl.memEn   = 1'b1;
                ctrl.memWr   = 1'b1;
            end
            OP_STU: begin
                // rs takes the effective address
                ctrl.regDst     = DEST_RS;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM5;
                ctrl.memEn      = 1'b1;
                ctrl.memWr      = 1'b1;
            end
            OP_LBI: begin
                ctrl.regDst     = DEST_RS;
                ctrl.regDataSrc = SRC_IMM8;
                ctrl.regWriteEn = 1'b1;
            end
            OP_SLBI: begin
                ctrl.regDst     = DEST_RS;
                ctrl.regWriteEn = 1'b1;
                ctrl.aluSrc2    = ALU2_IMM8;
                ctrl.aluOp      = ALU_SLBI;
                ctrl.signedExt  = 1'b0;
            end
            OP_BTR: begin
                ctrl.regDataSrc = SRC_BTR;
                ctrl.regWriteEn = 1'b1;
            end
            OP_BEQZ: begin
                ctrl.branch  = 1'b1;
                ctrl.aluSrc1 = ALU1_PC;
                ctrl.aluSrc2 = ALU2_IMM8;
            end
            OP_J: begin
                ctrl.jump    = 1'b1;
                ctrl.aluSrc1 = ALU1_PC;
                ctrl.aluSrc2 = ALU2_IMM11;
            end
            OP_JAL: begin
                ctrl.jump       = 1'b1;
                ctrl.aluSrc1    = ALU1_PC;
                ctrl.aluSrc2    = ALU2_IMM11;
                ctrl.regDst     = DEST_LINK;
                ctrl.regDataSrc = SRC_LINK;
                ctrl.regWriteEn = 1'b1;
            end
            default: begin
                // undefined opcode
                ctrl.exception  = 1'b1;
                ctrl.regWriteEn = 1'b0;
            end
        endcase
    end

endmodule

/* source/registerFile.sv */
`include "decode_config.svh"

module registerFile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`REG_INDEX_WIDTH-1:0] readSel1,
    input  logic [`REG_INDEX_WIDTH-1:0] readSel2,
    input  logic [`REG_INDEX_WIDTH-1:0] writeReg,
    input  logic [`DATA_WIDTH-1:0]      writeData,
    input  logic                        writeEn,
    output logic [`DATA_WIDTH-1:0]      readData1,
    output logic [`DATA_WIDTH-1:0]      readData2
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // no bypass, new data shows after the edge
    assign readData1 = regs[readSel1];
    assign readData2 = regs[readSel2];

endmodule

/* source/operandFormatter.sv */
`include "decode_config.svh"

module operandFormatter (
    input  decodePkg::instrWord_t         instr,
    input  decodePkg::controlSignals_t    ctrl,
    input  logic [`DATA_WIDTH-1:0]        readData1,
    output logic [`REG_INDEX_WIDTH-1:0]   writeReg,
    output decodePkg::formattedOperands_t operands
);
    import decodePkg::*;

    logic signFive;
    logic signEight;
    logic signEleven;

    // destination register select
    always_comb begin
        case (ctrl.regDst)
            DEST_RD: writeReg = instr.regView.rd;
            DEST_RT: writeReg = instr.immView.rd;
            DEST_RS: writeReg = instr.regView.rs;
            // link register is r7
            default: writeReg = '1;
        endcase
    end

    // fill bits, zero when extension is unsigned
    assign signFive   = ctrl.signedExt & instr.immView.imm[4];
    assign signEight  = ctrl.signedExt & instr.jumpView.disp[7];
    assign signEleven = ctrl.signedExt & instr.jumpView.disp[10];

    always_comb begin
        operands.immFive   = {{(`DATA_WIDTH-5){signFive}}, instr.immView.imm};
        operands.immEight  = {{(`DATA_WIDTH-8){signEight}}, instr.jumpView.disp[7:0]};
        operands.immEleven = {{(`DATA_WIDTH-11){signEleven}}, instr.jumpView.disp};
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            operands.bitReverse[i] = readData1[`DATA_WIDTH-1-i];
        end
    end

endmodule

/* source/decodeStage.sv */
`include "decode_config.svh"

module decodeStage (
    input  logic                          clk,
    input  logic                          reset,
    input  decodePkg::instrWord_t         instr,
    input  logic [`DATA_WIDTH-1:0]        writeData,
    input  logic                          regWriteEnIn,
    output decodePkg::controlSignals_t    ctrl,
    output logic                          regWriteEnOut,
    output logic [`DATA_WIDTH-1:0]        readData1,
    output logic [`DATA_WIDTH-1:0]        readData2,
    output decodePkg::formattedOperands_t operands
);

    logic [`REG_INDEX_WIDTH-1:0] writeReg;

    controlDecoder controlDecoder_inst (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // port 2 reads the immediate-format rd, bits 7 to 5
    registerFile registerFile_inst (
        .clk       (clk),
        .reset     (reset),
        .readSel1  (instr.regView.rs),
        .readSel2  (instr.immView.rd),
        .writeReg  (writeReg),
        .writeData (writeData),
        .writeEn   (regWriteEnIn),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    operandFormatter operandFormatter_inst (
        .instr     (instr),
        .ctrl      (ctrl),
        .readData1 (readData1),
        .writeReg  (writeReg),
        .operands  (operands)
    );

    // write-back stage returns this as regWriteEnIn
    assign regWriteEnOut = ctrl.regWriteEn;

endmodule

/* testbench/decodeStageTb.sv */
`include "decode_config.svh"

module decodeStageTb;
    import decodePkg::*;

    // reset, reads, opcode table, alu funcs, undefined, writes, jal, disabled, random
    localparam int STIM_CYCLES = 4 + 8 + 16 + 4 + 20 + 40 + 2 + 20 + 40;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 20;

    logic                   clk;
    logic                   reset;
    instrWord_t             instr;
    logic [`DATA_WIDTH-1:0] writeData;
    logic                   regWriteEnIn;
    controlSignals_t        ctrl;
    logic                   regWriteEnOut;
    logic [`DATA_WIDTH-1:0] readData1;
    logic [`DATA_WIDTH-1:0] readData2;
    formattedOperands_t     operands;

    logic [`DATA_WIDTH-1:0]   model [`REG_COUNT];
    logic [`OPCODE_WIDTH-1:0] opList [16];
    int errorCount = 0;
    int cycleCount = 0;

    decodeStage decodeStage_inst (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .writeData     (writeData),
        .regWriteEnIn  (regWriteEnIn),
        .ctrl          (ctrl),
        .regWriteEnOut (regWriteEnOut),
        .readData1     (readData1),
        .readData2     (readData2),
        .operands      (operands)
    );

    function automatic controlSignals_t expectedCtrl(input logic [15:0] word);
        controlSignals_t c;
        logic [4:0] op;
        op = word[15:11];
        c = '0;
        c.regWriteEn = op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ALU, OP_LD,
                                  OP_STU, OP_LBI, OP_SLBI, OP_BTR, OP_JAL};
        c.memEn = op inside {OP_LD, OP_ST, OP_STU};
        c.memWr = op inside {OP_ST, OP_STU};
        c.branch = (op == OP_BEQZ);
        c.jump = op inside {OP_J, OP_JAL};
        c.dump = (op == OP_HALT);
        c.invA = (op == OP_SUBI) || (op == OP_ALU && word[1:0] == FN_SUB);
        c.cin = c.invA;
        c.invB = (op == OP_ANDNI) || (op == OP_ALU && word[1:0] == FN_ANDN);
        c.signedExt = !(op inside {OP_XORI, OP_ANDNI, OP_SLBI});
        c.exception = !(op inside {OP_HALT, OP_NOP, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                                   OP_BEQZ, OP_J, OP_JAL, OP_ST, OP_LD, OP_STU, OP_SLBI,
                                   OP_LBI, OP_BTR, OP_ALU});
        // add and subtract share the adder
        if (op == OP_XORI || (op == OP_ALU && word[1:0] == FN_XOR)) c.aluOp = ALU_XOR;
        if (op == OP_ANDNI || (op == OP_ALU && word[1:0] == FN_ANDN)) c.aluOp = ALU_AND;
        if (op == OP_SLBI) c.aluOp = ALU_SLBI;
        if (op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD}) c.regDst = DEST_RT;
        if (op inside {OP_STU, OP_LBI, OP_SLBI}) c.regDst = DEST_RS;
        if (op == OP_JAL) c.regDst = DEST_LINK;
        if (op == OP_LD) c.regDataSrc = SRC_MEM;
        if (op == OP_LBI) c.regDataSrc = SRC_IMM8;
        if (op == OP_JAL) c.regDataSrc = SRC_LINK;
        if (op == OP_BTR) c.regDataSrc = SRC_BTR;
        return c;
    endfunction

    // alu operand selects and sign flag are left out of the comparison
    function automatic controlSignals_t maskCtrl(input controlSignals_t c);
        controlSignals_t m;
        m = c;
        m.aluSrc1 = '0;
        m.aluSrc2 = '0;
        m.sign = 1'b0;
        return m;
    endfunction

    function automatic logic [2:0] destReg(input logic [15:0] word, input regDest_t dst);
        case (dst)
            DEST_RD: return word[4:2];
            DEST_RT: return word[7:5];
            DEST_RS: return word[10:8];
            default: return 3'd7;
        endcase
    endfunction

    function automatic formattedOperands_t expectedOperands(input logic [15:0] word,
                                                            input logic [15:0] rsValue);
        formattedOperands_t o;
        logic s;
        s = expectedCtrl(word).signedExt;
        o.immFive = s ? {{11{word[4]}}, word[4:0]} : {11'd0, word[4:0]};
        o.immEight = s ? {{8{word[7]}}, word[7:0]} : {8'd0, word[7:0]};
        o.immEleven = s ? {{5{word[10]}}, word[10:0]} : {5'd0, word[10:0]};
        for (int i = 0; i < 16; i++) begin
            o.bitReverse[i] = rsValue[15-i];
        end
        return o;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic driveCycle(input logic [15:0] word, input logic [15:0] data, input logic en);
        @(posedge clk);
        instr <= word;
        writeData <= data;
        regWriteEnIn <= en;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // compare just before each edge, then track the write that edge performs
    initial begin
        logic [15:0] word;
        controlSignals_t expCtrl;
        forever begin
            @(posedge clk);
            #19;
            word = instr;
            expCtrl = expectedCtrl(word);
            if (reset) begin
                for (int i = 0; i < `REG_COUNT; i++) model[i] = '0;
            end else begin
                checkValue("ctrl", 64'(maskCtrl(ctrl)), 64'(maskCtrl(expCtrl)));
                checkValue("regWriteEnOut", 64'(regWriteEnOut), 64'(expCtrl.regWriteEn));
                checkValue("readData1", 64'(readData1), 64'(model[word[10:8]]));
                checkValue("readData2", 64'(readData2), 64'(model[word[7:5]]));
                checkValue("operands", operands, expectedOperands(word, model[word[10:8]]));
                if (regWriteEnIn) model[destReg(word, expCtrl.regDst)] = writeData;
            end
        end
    end

    initial begin
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: stimulus did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [15:0] w;
        void'($urandom(59712));
        opList = '{OP_HALT, OP_NOP, OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_BEQZ, OP_J,
                   OP_JAL, OP_ST, OP_LD, OP_STU, OP_SLBI, OP_LBI, OP_BTR, OP_ALU};
        reset <= 1'b1;
        instr <= {OP_NOP, 11'd0};
        writeData <= '0;
        regWriteEnIn <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        // all registers read back zero
        for (int i = 0; i < 8; i++) driveCycle({OP_NOP, 3'(i), 3'(i), 5'd0}, 16'd0, 1'b0);
        for (int i = 0; i < 16; i++) driveCycle({opList[i], 11'($urandom)}, 16'd0, 1'b0);
        for (int f = 0; f < 4; f++) driveCycle({OP_ALU, 9'($urandom), 2'(f)}, 16'd0, 1'b0);
        for (int i = 0; i < 20; i++) driveCycle(16'($urandom), 16'd0, 1'b0);
        for (int i = 0; i < 40; i++) begin
            w = {opList[4'($urandom)], 11'($urandom)};
            driveCycle(w, 16'($urandom), 1'b1);
        end
        driveCycle({OP_JAL, 11'($urandom)}, 16'($urandom), 1'b1);
        driveCycle({OP_NOP, 3'd7, 3'd7, 5'd0}, 16'd0, 1'b0);
        // writes held off, data still toggling
        for (int i = 0; i < 20; i++) driveCycle(16'($urandom), 16'($urandom), 1'b0);
        for (int i = 0; i < 40; i++) driveCycle(16'($urandom), 16'd0, 1'b0);
        repeat (2) @(posedge clk);
        $display("Run complete with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/decodePkg.sv
source/controlDecoder.sv
source/registerFile.sv
source/operandFormatter.sv
source/decodeStage.sv
testbench/decodeStageTb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = decodeStageTb
DUT_TOP    = decodeStage
FILELIST   = build.f

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
